/* include/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and pc width
`define RV_XLEN 32

// architectural integer registers
`define RV_NUM_REGS 32

// bits needed to name one register
`define RV_REG_IDX_W 5

// shift amount taken from the low operand bits
`define RV_SHAMT_W 5

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* verilog/rv_isa_pkg.sv */
`include "rv_defs.svh"

package rv_isa_pkg;

  // major opcodes handled by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_BRANCH = 7'b1100011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // immediate forms reuse the register form codes
  typedef enum logic [4:0] {
    ALU_NOP,
    ALU_LUI,
    ALU_AUIPC,
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU,
    ALU_ECALL
  } alu_op_e;

  // funct3 values for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 values for BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // selects sub and sra
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // r view, i-type imm sits in funct7 and rs2
  typedef struct packed {
    logic [6:0]               funct7;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [2:0]               funct3;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [6:0]               opcode;
  } r_fields_t;

  // b view with the scattered branch offset
  typedef struct packed {
    logic                     imm_12;
    logic [5:0]               imm_10_5;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [2:0]               funct3;
    logic [3:0]               imm_4_1;
    logic                     imm_11;
    logic [6:0]               opcode;
  } b_fields_t;

  typedef union packed {
    r_fields_t r;
    b_fields_t b;
  } insn_u;

endpackage

/* verilog/pipe_pkg.sv */
`include "rv_defs.svh"

package pipe_pkg;
  import rv_isa_pkg::*;

  // reset value must stay zero so cleared stages read as reset bubbles
  typedef enum logic [1:0] {
    CYCLE_RESET        = 2'd0,
    CYCLE_NO_STALL     = 2'd1,
    CYCLE_TAKEN_BRANCH = 2'd2
  } cycle_status_e;

  // contents of the decode stage register
  typedef struct packed {
    logic [`RV_XLEN-1:0]      pc;
    logic [`RV_XLEN-1:0]      insn;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_XLEN-1:0]      imm;
    logic                     use_imm;
    logic                     reg_write;
    alu_op_e                  alu_op;
    cycle_status_e            status;
  } decode_t;

  // decode fields plus the operands read in decode
  typedef struct packed {
    logic [`RV_XLEN-1:0]      pc;
    logic [`RV_XLEN-1:0]      insn;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_XLEN-1:0]      imm;
    logic                     use_imm;
    logic                     reg_write;
    alu_op_e                  alu_op;
    cycle_status_e            status;
    logic [`RV_XLEN-1:0]      rs1_data;
    logic [`RV_XLEN-1:0]      rs2_data;
  } exec_t;

  // memory and writeback stage contents
  typedef struct packed {
    logic [`RV_XLEN-1:0]      pc;
    logic [`RV_XLEN-1:0]      insn;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_XLEN-1:0]      rd_data;
    logic                     reg_write;
    logic                     ecall;
    cycle_status_e            status;
  } commit_t;

endpackage

/* verilog/insn_decode.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module insn_decode
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  insn_u               insn,
  input  logic [`RV_XLEN-1:0] pc,
  output decode_t             dec
);

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_b;
  logic                f7_zero;
  logic                f7_alt;
  logic                writes_rd;

  // i-type imm lives where funct7 and rs2 sit
  assign imm_i = {{(`RV_XLEN-12){insn.r.funct7[6]}}, insn.r.funct7, insn.r.rs2};
  // upper 20 bits straight from the r view
  assign imm_u = {insn.r.funct7, insn.r.rs2, insn.r.rs1, insn.r.funct3, 12'b0};
  // reassemble the split offset, bit 0 always zero
  assign imm_b = {{(`RV_XLEN-12){insn.b.imm_12}}, insn.b.imm_11, insn.b.imm_10_5,
                  insn.b.imm_4_1, 1'b0};

  assign f7_zero = insn.r.funct7 == 7'b0;
  assign f7_alt  = insn.r.funct7 == F7_ALT;

  always_comb begin
    dec        = '0;
    dec.pc     = pc;
    dec.insn   = insn;
    dec.alu_op = ALU_NOP;
    dec.status = CYCLE_NO_STALL;
    writes_rd  = 1'b0;
    case (insn.r.opcode)
      OPC_OP: begin
        dec.rs1   = insn.r.rs1;
        dec.rs2   = insn.r.rs2;
        dec.rd    = insn.r.rd;
        writes_rd = 1'b1;
        case (insn.r.funct3)
          F3_ADD_SUB: dec.alu_op = f7_zero ? ALU_ADD : (f7_alt ? ALU_SUB : ALU_NOP);
          F3_SLL:     dec.alu_op = f7_zero ? ALU_SLL : ALU_NOP;
          F3_SLT:     dec.alu_op = f7_zero ? ALU_SLT : ALU_NOP;
          F3_SLTU:    dec.alu_op = f7_zero ? ALU_SLTU : ALU_NOP;
          F3_XOR:     dec.alu_op = f7_zero ? ALU_XOR : ALU_NOP;
          F3_SRL_SRA: dec.alu_op = f7_zero ? ALU_SRL : (f7_alt ? ALU_SRA : ALU_NOP);
          F3_OR:      dec.alu_op = f7_zero ? ALU_OR : ALU_NOP;
          F3_AND:     dec.alu_op = f7_zero ? ALU_AND : ALU_NOP;
        endcase
      end
      OPC_OP_IMM: begin
        dec.rs1     = insn.r.rs1;
        dec.rd      = insn.r.rd;
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        writes_rd   = 1'b1;
        case (insn.r.funct3)
          F3_ADD_SUB: dec.alu_op = ALU_ADD;
          F3_SLL:     dec.alu_op = f7_zero ? ALU_SLL : ALU_NOP;
          F3_SLT:     dec.alu_op = ALU_SLT;
          F3_SLTU:    dec.alu_op = ALU_SLTU;
          F3_XOR:     dec.alu_op = ALU_XOR;
          // srai keeps its funct7 in imm[11:5], the alu only looks at imm[4:0]
          F3_SRL_SRA: dec.alu_op = f7_zero ? ALU_SRL : (f7_alt ? ALU_SRA : ALU_NOP);
          F3_OR:      dec.alu_op = ALU_OR;
          F3_AND:     dec.alu_op = ALU_AND;
        endcase
      end
      OPC_BRANCH: begin
        dec.rs1 = insn.b.rs1;
        dec.rs2 = insn.b.rs2;
        dec.imm = imm_b;
        case (insn.b.funct3)
          F3_BEQ:  dec.alu_op = ALU_BEQ;
          F3_BNE:  dec.alu_op = ALU_BNE;
          F3_BLT:  dec.alu_op = ALU_BLT;
          F3_BGE:  dec.alu_op = ALU_BGE;
          F3_BLTU: dec.alu_op = ALU_BLTU;
          F3_BGEU: dec.alu_op = ALU_BGEU;
          default: dec.alu_op = ALU_NOP;
        endcase
      end
      OPC_LUI, OPC_AUIPC: begin
        dec.rd      = insn.r.rd;
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        writes_rd   = 1'b1;
        dec.alu_op  = (insn.r.opcode == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
      end
      OPC_SYSTEM: begin
        // only the plain ecall encoding, everything else stays nop
        if ({insn.r.funct7, insn.r.rs2, insn.r.rs1, insn.r.funct3, insn.r.rd} == '0) begin
          dec.alu_op = ALU_ECALL;
        end
      end
      default: begin
        dec.alu_op = ALU_NOP;
      end
    endcase
    // x0 and invalid encodings never write
    dec.reg_write = writes_rd && (dec.alu_op != ALU_NOP) && (dec.rd != '0);
  end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module reg_file
  import pipe_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`RV_REG_IDX_W-1:0] rs1,
  input  logic [`RV_REG_IDX_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]      rs1_data,
  output logic [`RV_XLEN-1:0]      rs2_data,
  input  commit_t                  wr
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // reg_write is already low for x0 so regs[0] stays zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.reg_write) begin
      regs[wr.rd] <= wr.rd_data;
    end
  end

  // write-through covers writeback to decode
  assign rs1_data = (wr.reg_write && wr.rd == rs1) ? wr.rd_data : regs[rs1];
  assign rs2_data = (wr.reg_write && wr.rd == rs2) ? wr.rd_data : regs[rs2];

endmodule

/* verilog/operand_forward.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module operand_forward
  import pipe_pkg::*;
(
  input  exec_t               ex,
  input  commit_t             mem,
  input  commit_t             wb,
  output logic [`RV_XLEN-1:0] op_a,
  output logic [`RV_XLEN-1:0] op_b
);

  // memory first since it holds the younger result
  function automatic logic [`RV_XLEN-1:0] pick(
    input logic [`RV_REG_IDX_W-1:0] idx,
    input logic [`RV_XLEN-1:0]      latched,
    input commit_t                  m,
    input commit_t                  w
  );
    logic [`RV_XLEN-1:0] val;
    val = latched;
    if (m.reg_write && m.rd == idx) begin
      val = m.rd_data;
    end else if (w.reg_write && w.rd == idx) begin
      val = w.rd_data;
    end
    return val;
  endfunction

  // no x0 check here, decode never sets reg_write for x0
  assign op_a = pick(ex.rs1, ex.rs1_data, mem, wb);
  assign op_b = pick(ex.rs2, ex.rs2_data, mem, wb);

endmodule

/* verilog/alu_branch.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module alu_branch
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  exec_t               ex,
  input  logic [`RV_XLEN-1:0] op_a,
  input  logic [`RV_XLEN-1:0] op_b,
  output logic [`RV_XLEN-1:0] rd_data,
  output logic                branch_taken,
  output logic [`RV_XLEN-1:0] branch_target,
  output logic                ecall
);

  logic [`RV_XLEN-1:0]    src_b;
  logic [`RV_SHAMT_W-1:0] shamt;
  logic                   eq;
  logic                   lt_s;
  logic                   lt_u;

  // immediate replaces rs2 for op-imm, lui, auipc
  assign src_b = ex.use_imm ? ex.imm : op_b;
  assign shamt = src_b[`RV_SHAMT_W-1:0];

  // branches never set use_imm, so src_b is rs2 there
  // one comparator set serves slt and all six conditions
  assign eq   = op_a == src_b;
  assign lt_s = $signed(op_a) < $signed(src_b);
  assign lt_u = op_a < src_b;

  assign branch_target = ex.pc + ex.imm;

  always_comb begin
    rd_data      = '0;
    branch_taken = 1'b0;
    ecall        = 1'b0;
    case (ex.alu_op)
      ALU_LUI:   rd_data = src_b;
      ALU_AUIPC: rd_data = ex.pc + src_b;
      ALU_ADD:   rd_data = op_a + src_b;
      ALU_SUB:   rd_data = op_a - src_b;
      ALU_SLL:   rd_data = op_a << shamt;
      ALU_SLT:   rd_data = {{(`RV_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:  rd_data = {{(`RV_XLEN-1){1'b0}}, lt_u};
      ALU_XOR:   rd_data = op_a ^ src_b;
      ALU_SRL:   rd_data = op_a >> shamt;
      ALU_SRA:   rd_data = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:    rd_data = op_a | src_b;
      ALU_AND:   rd_data = op_a & src_b;
      // conditional branches
      ALU_BEQ:   branch_taken = eq;
      ALU_BNE:   branch_taken = !eq;
      ALU_BLT:   branch_taken = lt_s;
      ALU_BGE:   branch_taken = !lt_s;
      ALU_BLTU:  branch_taken = lt_u;
      ALU_BGEU:  branch_taken = !lt_u;
      ALU_ECALL: ecall = 1'b1;
      default: begin
        rd_data = '0;
      end
    endcase
  end

endmodule

/* verilog/rv_pipeline.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_pipeline
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  output logic [`RV_XLEN-1:0]      pc_to_imem,
  input  logic [`RV_XLEN-1:0]      insn_from_imem,
  output logic                     halt,
  output logic [`RV_XLEN-1:0]      trace_pc,
  output logic [`RV_XLEN-1:0]      trace_insn,
  output cycle_status_e            trace_status,
  output logic [`RV_REG_IDX_W-1:0] trace_rd,
  output logic [`RV_XLEN-1:0]      trace_rd_data,
  output logic                     trace_reg_write
);

  logic [`RV_XLEN-1:0] f_pc;
  insn_u               f_insn;
  decode_t             f_dec;
  decode_t             d_q;
  exec_t               d_to_x;
  exec_t               x_q;
  commit_t             m_q;
  commit_t             w_q;
  logic [`RV_XLEN-1:0] d_rs1_data;
  logic [`RV_XLEN-1:0] d_rs2_data;
  logic [`RV_XLEN-1:0] x_op_a;
  logic [`RV_XLEN-1:0] x_op_b;
  logic [`RV_XLEN-1:0] x_rd_data;
  logic [`RV_XLEN-1:0] x_target;
  logic                x_taken;
  logic                x_ecall;
  logic                halt_q;

  // bubbles carry zero pc and insn and never write
  function automatic decode_t dec_bubble(input cycle_status_e st);
    decode_t b;
    b        = '0;
    b.alu_op = ALU_NOP;
    b.status = st;
    return b;
  endfunction

  function automatic exec_t exec_bubble(input cycle_status_e st);
    exec_t b;
    b        = '0;
    b.alu_op = ALU_NOP;
    b.status = st;
    return b;
  endfunction

  function automatic commit_t commit_bubble();
    commit_t b;
    b        = '0;
    b.status = CYCLE_RESET;
    return b;
  endfunction

  // fetch, imem answers in the same cycle
  assign pc_to_imem = f_pc;
  assign f_insn     = insn_from_imem;

  always_ff @(posedge clk) begin
    if (rst) begin
      f_pc <= `RV_RESET_PC;
    end else if (x_taken) begin
      f_pc <= x_target;
    end else begin
      f_pc <= f_pc + 4;
    end
  end

  insn_decode u_decode (
    .insn (f_insn),
    .pc   (f_pc),
    .dec  (f_dec)
  );

  // decode stage, a taken branch kills the word being fetched
  always_ff @(posedge clk) begin
    if (rst) begin
      d_q <= dec_bubble(CYCLE_RESET);
    end else if (x_taken) begin
      d_q <= dec_bubble(CYCLE_TAKEN_BRANCH);
    end else begin
      d_q <= f_dec;
    end
  end

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (d_q.rs1),
    .rs2      (d_q.rs2),
    .rs1_data (d_rs1_data),
    .rs2_data (d_rs2_data),
    .wr       (w_q)
  );

  assign d_to_x = '{
    pc:        d_q.pc,
    insn:      d_q.insn,
    rs1:       d_q.rs1,
    rs2:       d_q.rs2,
    rd:        d_q.rd,
    imm:       d_q.imm,
    use_imm:   d_q.use_imm,
    reg_write: d_q.reg_write,
    alu_op:    d_q.alu_op,
    status:    d_q.status,
    rs1_data:  d_rs1_data,
    rs2_data:  d_rs2_data
  };

  // execute stage, the instruction in decode is squashed too
  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= exec_bubble(CYCLE_RESET);
    end else if (x_taken) begin
      x_q <= exec_bubble(CYCLE_TAKEN_BRANCH);
    end else begin
      x_q <= d_to_x;
    end
  end

  operand_forward u_fwd (
    .ex   (x_q),
    .mem  (m_q),
    .wb   (w_q),
    .op_a (x_op_a),
    .op_b (x_op_b)
  );

  alu_branch u_alu (
    .ex            (x_q),
    .op_a          (x_op_a),
    .op_b          (x_op_b),
    .rd_data       (x_rd_data),
    .branch_taken  (x_taken),
    .branch_target (x_target),
    .ecall         (x_ecall)
  );

  // memory then writeback, no data memory so both just carry the result
  always_ff @(posedge clk) begin
    if (rst) begin
      m_q <= commit_bubble();
      w_q <= commit_bubble();
    end else begin
      m_q <= '{
        pc:        x_q.pc,
        insn:      x_q.insn,
        rd:        x_q.rd,
        rd_data:   x_rd_data,
        reg_write: x_q.reg_write,
        ecall:     x_ecall,
        status:    x_q.status
      };
      w_q <= m_q;
    end
  end

  // sticky halt
  always_ff @(posedge clk) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else if (w_q.ecall) begin
      halt_q <= 1'b1;
    end
  end

  // rises together with the ecall in writeback
  assign halt = halt_q | w_q.ecall;

  assign trace_pc        = w_q.pc;
  assign trace_insn      = w_q.insn;
  assign trace_status    = w_q.status;
  assign trace_rd        = w_q.rd;
  assign trace_rd_data   = w_q.rd_data;
  assign trace_reg_write = w_q.reg_write;

endmodule

/* sim/tb_arch_model.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_arch_model;

  logic [`RV_XLEN-1:0] prog [256];
  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];
  logic [`RV_XLEN-1:0] pc;

  task automatic clear();
    pc = `RV_RESET_PC;
    for (int i = 0; i < 256; i++) begin
      prog[i] = '0;
    end
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      regs[i] = '0;
    end
  endtask

  task automatic load_word(input int idx, input logic [`RV_XLEN-1:0] w);
    prog[idx] = w;
  endtask

  // integer op from funct3, alt picks sub or sra
  function automatic logic [`RV_XLEN-1:0] int_op(
    input logic [2:0]          f3,
    input logic                alt,
    input logic [`RV_XLEN-1:0] a,
    input logic [`RV_XLEN-1:0] b
  );
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $unsigned($signed(a) >>> b[4:0]);
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // branch condition from funct3
  function automatic logic branch_cond(
    input logic [2:0]          f3,
    input logic [`RV_XLEN-1:0] a,
    input logic [`RV_XLEN-1:0] b
  );
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // executes the word at pc and reports its commit
  task automatic step(
    output logic [`RV_XLEN-1:0]      c_pc,
    output logic [`RV_XLEN-1:0]      c_insn,
    output logic [`RV_REG_IDX_W-1:0] c_rd,
    output logic [`RV_XLEN-1:0]      c_data,
    output logic                     c_wr,
    output logic                     c_ecall,
    output logic                     c_taken
  );
    logic [`RV_XLEN-1:0] w;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    w       = prog[pc[9:2]];
    a       = regs[w[19:15]];
    b       = regs[w[24:20]];
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    c_pc    = pc;
    c_insn  = w;
    c_rd    = w[11:7];
    c_data  = '0;
    c_wr    = 1'b0;
    c_ecall = 1'b0;
    c_taken = 1'b0;
    case (w[6:0])
      7'b0110011: begin
        c_data = int_op(w[14:12], w[30], a, b);
        c_wr   = 1'b1;
      end
      7'b0010011: begin
        // only srai carries the alt bit in its immediate
        c_data = int_op(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm_i);
        c_wr   = 1'b1;
      end
      7'b0110111: begin
        c_data = {w[31:12], 12'b0};
        c_wr   = 1'b1;
      end
      7'b0010111: begin
        c_data = pc + {w[31:12], 12'b0};
        c_wr   = 1'b1;
      end
      7'b1100011: begin
        c_taken = branch_cond(w[14:12], a, b);
      end
      7'b1110011: begin
        c_ecall = w[31:7] == '0;
      end
      default: begin
        c_wr = 1'b0;
      end
    endcase
    // x0 is hardwired
    c_wr = c_wr && (c_rd != '0);
    if (c_wr) begin
      regs[c_rd] = c_data;
    end
    pc = c_taken ? pc + imm_b : pc + 4;
  endtask

endmodule

/* sim/tb_rv_pipeline.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_pipeline
  import pipe_pkg::*;
();

  localparam int PROG_WORDS     = 256;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int HALT_HOLD      = 5;
  localparam int NUM_TESTS      = 6;
  localparam int T_RESET        = 0;
  localparam int T_ALU          = 1;
  localparam int T_FWD          = 2;
  localparam int T_TAKEN        = 3;
  localparam int T_NOT_TAKEN    = 4;
  localparam int T_HALT         = 5;
  localparam logic [31:0] NOP   = 32'h0000_0013;

  logic                     clk;
  logic                     rst;
  logic [`RV_XLEN-1:0]      pc_to_imem;
  logic [`RV_XLEN-1:0]      insn_from_imem;
  logic                     halt;
  logic [`RV_XLEN-1:0]      trace_pc;
  logic [`RV_XLEN-1:0]      trace_insn;
  cycle_status_e            trace_status;
  logic [`RV_REG_IDX_W-1:0] trace_rd;
  logic [`RV_XLEN-1:0]      trace_rd_data;
  logic                     trace_reg_write;

  logic [`RV_XLEN-1:0] imem [PROG_WORDS];
  int prog_len         = 0;
  int expected_commits = 0;
  int commit_count     = 0;
  int sec_start   [NUM_TESTS];
  int test_checks [NUM_TESTS];
  int test_errs   [NUM_TESTS];
  string test_name [NUM_TESTS] = '{"reset state", "independent alu", "forwarding",
                                   "taken branches", "not-taken branches", "halt"};
  int cur_test     = T_RESET;
  bit first_seen   = 1'b0;
  int reset_cycles = 0;
  int bubbles_due  = 0;
  bit ecall_seen   = 1'b0;
  int hold_cycles  = 0;
  bit timed_out    = 1'b0;

  // branch operands, x6 holds -5 and x7 holds 7
  logic [2:0] br_f3  [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  logic [4:0] tk_rs1 [6] = '{5'd6, 5'd6, 5'd6, 5'd7, 5'd7, 5'd6};
  logic [4:0] tk_rs2 [6] = '{5'd6, 5'd7, 5'd7, 5'd6, 5'd6, 5'd7};
  logic [4:0] nt_rs1 [6] = '{5'd6, 5'd6, 5'd7, 5'd6, 5'd6, 5'd7};
  logic [4:0] nt_rs2 [6] = '{5'd7, 5'd6, 5'd6, 5'd7, 5'd7, 5'd6};

  rv_pipeline dut (
    .clk             (clk),
    .rst             (rst),
    .pc_to_imem      (pc_to_imem),
    .insn_from_imem  (insn_from_imem),
    .halt            (halt),
    .trace_pc        (trace_pc),
    .trace_insn      (trace_insn),
    .trace_status    (trace_status),
    .trace_rd        (trace_rd),
    .trace_rd_data   (trace_rd_data),
    .trace_reg_write (trace_reg_write)
  );

  tb_arch_model model ();

  always #10 clk = ~clk;

  // imem answers in the same cycle
  assign insn_from_imem = imem[pc_to_imem[9:2]];

  // instruction encoders per the base isa formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  // commits says whether the word is expected in the trace
  task automatic emit(input logic [31:0] w, input bit commits);
    imem[prog_len] = w;
    model.load_word(prog_len, w);
    if (commits) begin
      expected_commits++;
    end
    prog_len++;
  endtask

  task automatic pad(input int n);
    repeat (n) emit(NOP, 1'b1);
  endtask

  task automatic mark(input int t);
    sec_start[t] = prog_len * 4;
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    logic [11:0] imm;
    // random operands in x1 and x2, auipc into x3
    mark(T_ALU);
    rnd = $urandom();
    emit(u_type(rnd[31:12], 5'd1, 7'b0110111), 1'b1);
    pad(3);
    rnd = $urandom();
    emit(i_type(rnd[11:0], 5'd1, 3'd0, 5'd1), 1'b1);
    pad(3);
    rnd = $urandom();
    emit(u_type(rnd[31:12], 5'd2, 7'b0110111), 1'b1);
    pad(3);
    rnd = $urandom();
    emit(i_type(rnd[11:0], 5'd2, 3'd0, 5'd2), 1'b1);
    pad(3);
    rnd = $urandom();
    emit(u_type(rnd[31:12], 5'd3, 7'b0010111), 1'b1);
    pad(3);
    // every funct3 in register and immediate form
    for (int f = 0; f < 8; f++) begin
      emit(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'(4 + f % 4)), 1'b1);
      pad(1);
      rnd = $urandom();
      imm = (f == 1 || f == 5) ? {7'h00, rnd[4:0]} : rnd[11:0];
      emit(i_type(imm, 5'd1, 3'(f), 5'(4 + (f + 1) % 4)), 1'b1);
      pad(1);
    end
    emit(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd5), 1'b1);
    pad(1);
    emit(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd6), 1'b1);
    pad(1);
    rnd = $urandom();
    emit(i_type({7'h20, rnd[4:0]}, 5'd1, 3'd5, 5'd7), 1'b1);
    pad(3);
    // dependent chains at distance 1, 2 and 3
    mark(T_FWD);
    for (int d = 1; d <= 3; d++) begin
      rnd = $urandom();
      emit(i_type(rnd[11:0], 5'd1, 3'd0, 5'd5), 1'b1);
      pad(d - 1);
      emit(r_type(7'h00, 5'd2, 5'd5, 3'd0, 5'd6), 1'b1);
      pad(d - 1);
      emit(r_type(7'h20, 5'd5, 5'd6, 3'd0, 5'd7), 1'b1);
      pad(3);
    end
    // x0 target right before x0 sources
    rnd = $urandom();
    emit(i_type(rnd[11:0], 5'd1, 3'd0, 5'd0), 1'b1);
    emit(r_type(7'h00, 5'd2, 5'd0, 3'd0, 5'd4), 1'b1);
    emit(r_type(7'h00, 5'd0, 5'd1, 3'd6, 5'd5), 1'b1);
    pad(3);
    // same rd in memory and writeback, younger wins
    rnd = $urandom();
    repeat (3) emit(i_type(rnd[11:0], 5'd5, 3'd0, 5'd5), 1'b1);
    pad(3);
    mark(T_TAKEN);
    emit(i_type(12'hffb, 5'd0, 3'd0, 5'd6), 1'b1);
    emit(i_type(12'h007, 5'd0, 3'd0, 5'd7), 1'b1);
    // two shadow words that must be squashed
    for (int i = 0; i < 6; i++) begin
      emit(b_type(13'd12, tk_rs2[i], tk_rs1[i], br_f3[i]), 1'b1);
      emit(i_type(12'h001, 5'd1, 3'd0, 5'd1), 1'b0);
      emit(i_type(12'h001, 5'd2, 3'd0, 5'd2), 1'b0);
      emit(r_type(7'h00, 5'd6, 5'd7, 3'd0, 5'd4), 1'b1);
    end
    // offset 8 would skip the addi if taken by mistake
    mark(T_NOT_TAKEN);
    for (int i = 0; i < 6; i++) begin
      emit(b_type(13'd8, nt_rs2[i], nt_rs1[i], br_f3[i]), 1'b1);
      emit(i_type(12'h001, 5'd3, 3'd0, 5'd3), 1'b1);
    end
    // zero words follow the ecall
    mark(T_HALT);
    emit(32'h0000_0073, 1'b1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    test_checks[cur_test]++;
    assert (act === exp) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      test_errs[cur_test]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %0d checks, %0d errors", t, test_name[t], test_checks[t],
             test_errs[t]);
  endtask

  // one trace cycle against the model, at negedge
  task automatic check_trace();
    logic [`RV_XLEN-1:0]      e_pc;
    logic [`RV_XLEN-1:0]      e_insn;
    logic [`RV_XLEN-1:0]      e_data;
    logic [`RV_REG_IDX_W-1:0] e_rd;
    logic                     e_wr;
    logic                     e_ecall;
    logic                     e_taken;
    if (!first_seen) begin
      if (reset_cycles == 0) begin
        check_val("pc_to_imem", `RV_RESET_PC, pc_to_imem);
      end
      if (trace_status == CYCLE_RESET) begin
        check_val("trace_reg_write", 32'd0, 32'(trace_reg_write));
        check_val("halt", 32'd0, 32'(halt));
        reset_cycles++;
        return;
      end
      // fetched in the first cycle out of reset, four edges to writeback
      first_seen = 1'b1;
      check_val("reset bubble cycles", 32'd4, reset_cycles);
      report_test(T_RESET);
      cur_test = T_ALU;
    end
    if (ecall_seen) begin
      check_val("halt", 32'd1, 32'(halt));
      hold_cycles++;
      return;
    end
    // retired words as the dut reports them
    if (trace_status == CYCLE_NO_STALL) begin
      commit_count++;
    end
    if (bubbles_due > 0) begin
      check_val("trace_status", 32'(CYCLE_TAKEN_BRANCH), 32'(trace_status));
      check_val("trace_reg_write", 32'd0, 32'(trace_reg_write));
      check_val("halt", 32'd0, 32'(halt));
      bubbles_due--;
      return;
    end
    model.step(e_pc, e_insn, e_rd, e_data, e_wr, e_ecall, e_taken);
    while (cur_test < T_HALT && int'(e_pc) >= sec_start[cur_test + 1]) begin
      report_test(cur_test);
      cur_test++;
    end
    check_val("trace_status", 32'(CYCLE_NO_STALL), 32'(trace_status));
    check_val("trace_pc", e_pc, trace_pc);
    check_val("trace_insn", e_insn, trace_insn);
    check_val("trace_reg_write", 32'(e_wr), 32'(trace_reg_write));
    if (e_wr) begin
      check_val("trace_rd", 32'(e_rd), 32'(trace_rd));
      check_val("trace_rd_data", e_data, trace_rd_data);
    end
    // halt goes up with the ecall in writeback
    check_val("halt", 32'(e_ecall), 32'(halt));
    if (e_taken) begin
      bubbles_due = 2;
    end
    if (e_ecall) begin
      ecall_seen = 1'b1;
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      check_trace();
    end
  end

  initial begin
    int waited;
    int total_checks;
    int total_errs;
    clk = 1'b0;
    rst = 1'b1;
    total_checks = 0;
    total_errs = 0;
    void'($urandom(32'hc793d2a2));
    for (int t = 0; t < NUM_TESTS; t++) begin
      sec_start[t] = 0;
      test_checks[t] = 0;
      test_errs[t] = 0;
    end
    for (int i = 0; i < PROG_WORDS; i++) begin
      imem[i] = '0;
    end
    model.clear();
    build_program();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    // run until the ecall commits
    waited = 0;
    while (!ecall_seen && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (!ecall_seen) begin
      $display("timeout: ECALL never reached writeback within %0d cycles", TIMEOUT_CYCLES);
      timed_out = 1'b1;
    end else begin
      // halt must hold while fetch runs on
      waited = 0;
      while (hold_cycles < HALT_HOLD && waited < TIMEOUT_CYCLES) begin
        @(posedge clk);
        waited++;
      end
      if (hold_cycles < HALT_HOLD) begin
        $display("timeout: trace stopped advancing after halt");
        timed_out = 1'b1;
      end
    end
    // every word up to the ecall committed, shadow words excluded
    check_val("commit count", expected_commits, commit_count);
    for (int t = cur_test; t < NUM_TESTS; t++) begin
      report_test(t);
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_checks += test_checks[t];
      total_errs += test_errs[t];
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks, total_errs);
    if (total_errs == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/insn_decode.sv
verilog/reg_file.sv
verilog/operand_forward.sv
verilog/alu_branch.sv
verilog/rv_pipeline.sv
sim/tb_arch_model.sv
sim/tb_rv_pipeline.sv
